/* logic/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // geometry
    localparam int INDEX_W   = 6;   // 64 sets
    localparam int OFFSET_W  = 6;   // byte offset in a line
    localparam int TAG_W     = 20;
    localparam int WORDS     = 16;  // words per line
    localparam int LINE_BITS = 512;

    // request mask codes, the only legal masks
    localparam logic [3:0] SIZE_BYTE = 4'b0001;
    localparam logic [3:0] SIZE_HALF = 4'b0011;
    localparam logic [3:0] SIZE_WORD = 4'b1111;

    // exception codes
    localparam logic [6:0] EXC_NONE = 7'h00;
    localparam logic [6:0] EXC_ALE  = 7'h09;  // address not aligned

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL,
        WAIT_WB
    } main_state_t;

    typedef enum logic [1:0] {
        WB_INIT,
        WB_WRITE,
        WB_DONE
    } wb_state_t;

    // loads pick a word, store merges work per byte
    typedef union packed {
        logic [WORDS-1:0][31:0]        words;
        logic [LINE_BITS/8-1:0][7:0]   bytes;
    } cache_line_u;

endpackage

`default_nettype wire

/* logic/dcache_ctrl.sv */
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       i_rvalid,
    input  logic       i_wvalid,
    input  logic       i_mem_rready,
    input  logic       i_mem_wready,
    input  logic       i_hit,
    input  logic       i_hit_way,
    input  logic       i_victim_way,
    input  logic       i_victim_dirty,
    input  logic       i_misaligned,
    input  logic       i_is_store,
    output logic       o_rready,
    output logic       o_wready,
    output logic       o_mem_rvalid,
    output logic       o_mem_wvalid,
    output logic       o_req_capture,
    output logic [1:0] o_tag_we,
    output logic [1:0] o_data_we,
    output logic       o_refill_sel,
    output logic       o_lru_we,
    output logic       o_lru_way,
    output logic [1:0] o_dirty_we,
    output logic       o_dirty_val,
    output logic       o_victim_capture,
    output logic       o_ret_capture,
    output logic       o_exc_valid
);

    main_state_t state, state_nxt;
    wb_state_t   wb_state, wb_nxt;

    logic req_valid;
    logic lookup_done;   // hit or exception, answered this cycle
    logic miss_start;
    logic wb_finished;
    logic complete;
    logic store_hit;

    assign req_valid   = i_rvalid | i_wvalid;
    assign lookup_done = (state == LOOKUP) && (i_misaligned || i_hit);
    assign miss_start  = (state == LOOKUP) && !i_misaligned && !i_hit;
    assign wb_finished = (wb_state == WB_DONE);
    assign complete    = lookup_done || ((state == WAIT_WB) && wb_finished);
    assign store_hit   = (state == LOOKUP) && i_hit && !i_misaligned && i_is_store;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= IDLE;
            wb_state <= WB_INIT;
        end else begin
            state    <= state_nxt;
            wb_state <= wb_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        unique case (state)
            IDLE:    if (req_valid) state_nxt = LOOKUP;
            LOOKUP: begin
                if (lookup_done) state_nxt = req_valid ? LOOKUP : IDLE;
                else state_nxt = MISS;
            end
            MISS:    if (i_mem_rready) state_nxt = REFILL;
            REFILL:  state_nxt = WAIT_WB;
            WAIT_WB: if (wb_finished) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // write-back runs beside the refill, started by the miss
    always_comb begin
        wb_nxt = wb_state;
        unique case (wb_state)
            WB_INIT:  if (miss_start) wb_nxt = i_victim_dirty ? WB_WRITE : WB_DONE;
            WB_WRITE: if (i_mem_wready) wb_nxt = WB_DONE;
            WB_DONE:  if (state == WAIT_WB) wb_nxt = WB_INIT;
            default:  wb_nxt = WB_INIT;
        endcase
    end

    assign o_rready      = complete && !i_is_store;
    assign o_wready      = complete && i_is_store;
    assign o_req_capture = ((state == IDLE) || lookup_done) && req_valid;
    assign o_exc_valid   = (state == LOOKUP) && i_misaligned;

    assign o_mem_rvalid     = (state == MISS);
    assign o_mem_wvalid     = (wb_state == WB_WRITE);
    assign o_ret_capture    = (state == MISS) && i_mem_rready;
    assign o_victim_capture = miss_start;

    assign o_refill_sel = (state == REFILL);
    assign o_tag_we     = o_refill_sel ? {i_victim_way, ~i_victim_way} : 2'b00;

    always_comb begin
        o_data_we   = 2'b00;
        o_dirty_we  = 2'b00;
        o_dirty_val = 1'b0;
        o_lru_we    = 1'b0;
        o_lru_way   = i_hit_way;
        if (o_refill_sel) begin
            o_data_we   = {i_victim_way, ~i_victim_way};
            o_dirty_we  = {i_victim_way, ~i_victim_way};
            o_dirty_val = i_is_store;           // a store miss leaves the line dirty
            o_lru_we    = 1'b1;
            o_lru_way   = i_victim_way;
        end else if (lookup_done && !i_misaligned) begin
            o_lru_we = 1'b1;
            if (store_hit) begin
                o_data_we   = {i_hit_way, ~i_hit_way};
                o_dirty_we  = {i_hit_way, ~i_hit_way};
                o_dirty_val = 1'b1;
            end
        end
    end

    // memory requests hold until taken
    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_rvalid && !i_mem_rready |=> o_mem_rvalid);
    a_wvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_wvalid && !i_mem_wready |=> o_mem_wvalid);
    // a miss answers only once its line sits in the cache
    a_miss_hit: assert property (@(posedge clk) disable iff (!rstn)
        (state == WAIT_WB) && (o_rready || o_wready) |-> i_hit);

endmodule

`default_nettype wire

/* logic/dcache_ways.sv */
`default_nettype none

module dcache_ways import dcache_pkg::*; (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic [31:0]                  i_addr,
    input  logic                         i_req_capture,
    input  logic [1:0]                   i_tag_we,
    input  logic [1:0]                   i_data_we,
    input  logic [LINE_BITS/8-1:0]       i_byte_en,
    input  logic                         i_refill_sel,
    input  cache_line_u                  i_line_wdata,
    output logic                         o_hit,
    output logic                         o_hit_way,
    output cache_line_u [1:0]            o_way_line,
    output logic [1:0][TAG_W-1:0]        o_way_tag,
    output logic [31:0]                  o_req_addr
);

    logic [TAG_W-1:0]           tag_mem  [2][2**INDEX_W];
    cache_line_u                data_mem [2][2**INDEX_W];
    logic [1:0][2**INDEX_W-1:0] valid_q;

    logic [INDEX_W-1:0]     idx;
    logic [TAG_W-1:0]       req_tag;
    logic [LINE_BITS/8-1:0] wr_en;
    logic [1:0]             hit_vec;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_req_addr <= '0;
        end else if (i_req_capture) begin
            o_req_addr <= i_addr;
        end
    end

    assign idx     = o_req_addr[OFFSET_W +: INDEX_W];
    assign req_tag = o_req_addr[31 -: TAG_W];
    assign wr_en   = i_refill_sel ? '1 : i_byte_en;    // refill writes the whole line

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (i_tag_we[w]) valid_q[w][idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (i_tag_we[w]) tag_mem[w][idx] <= req_tag;
            for (int b = 0; b < LINE_BITS/8; b++) begin
                if (i_data_we[w] && wr_en[b]) begin
                    data_mem[w][idx].bytes[b] <= i_line_wdata.bytes[b];
                end
            end
        end
    end

    // read on the held index
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            o_way_line[w] = data_mem[w][idx];
            o_way_tag[w]  = tag_mem[w][idx];
            hit_vec[w]    = valid_q[w][idx] && (tag_mem[w][idx] == req_tag);
        end
    end

    assign o_hit     = |hit_vec;
    assign o_hit_way = hit_vec[1];

    // a refill never places a tag already held in the other way
    a_one_hit: assert property (@(posedge clk) disable iff (!rstn)
        !(hit_vec[0] && hit_vec[1]));

endmodule

`default_nettype wire

/* logic/dcache_repl.sv */
`default_nettype none

module dcache_repl import dcache_pkg::*; (
    input  logic               clk,
    input  logic               rstn,
    input  logic [INDEX_W-1:0] i_index,
    input  logic               i_lru_we,
    input  logic               i_lru_way,
    input  logic [1:0]         i_dirty_we,
    input  logic               i_dirty_val,
    output logic               o_victim_way,
    output logic               o_victim_dirty
);

    logic [2**INDEX_W-1:0]      lru_q;    // way used last in each set
    logic [1:0][2**INDEX_W-1:0] dirty_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_q   <= '0;
            dirty_q <= '0;
        end else begin
            if (i_lru_we) lru_q[i_index] <= i_lru_way;
            for (int w = 0; w < 2; w++) begin
                if (i_dirty_we[w]) dirty_q[w][i_index] <= i_dirty_val;
            end
        end
    end

    assign o_victim_way   = ~lru_q[i_index];   // the other way goes
    assign o_victim_dirty = dirty_q[o_victim_way][i_index];

endmodule

`default_nettype wire

/* logic/dcache_align.sv */
`default_nettype none

module dcache_align import dcache_pkg::*; (
    input  logic                   clk,
    input  logic                   i_req_capture,
    input  logic                   i_is_store,
    input  logic [31:0]            i_wdata,
    input  logic [3:0]             i_wstrb,
    input  logic                   i_signed,
    input  logic [31:0]            i_req_addr,
    input  cache_line_u            i_src_line,     // refill line to merge into
    input  cache_line_u            i_hit_line,     // line that loads read from
    output logic                   o_req_store,
    output logic                   o_misaligned,
    output logic [LINE_BITS/8-1:0] o_byte_en,
    output cache_line_u            o_merge_line,
    output logic [31:0]            o_load_data
);

    logic [31:0] wdata_q;
    logic [3:0]  wstrb_q;
    logic        signed_q;

    logic [1:0]  lane;
    logic [31:0] word;
    logic [31:0] shifted;
    cache_line_u st_line;

    // request payload, captured beside the address
    always_ff @(posedge clk) begin
        if (i_req_capture) begin
            wdata_q     <= i_wdata;
            wstrb_q     <= i_wstrb;
            signed_q    <= i_signed;
            o_req_store <= i_is_store;
        end
    end

    assign lane = i_req_addr[1:0];

    always_comb begin
        unique case (wstrb_q)
            SIZE_HALF: o_misaligned = lane[0];
            SIZE_WORD: o_misaligned = (lane != 2'b00);
            default:   o_misaligned = 1'b0;
        endcase
    end

    // data and mask moved to their line position
    assign o_byte_en = o_req_store ?
        (LINE_BITS/8)'(wstrb_q) << i_req_addr[OFFSET_W-1:0] : '0;
    assign st_line = LINE_BITS'(wdata_q) << {i_req_addr[OFFSET_W-1:0], 3'b000};

    always_comb begin
        o_merge_line = i_src_line;
        for (int b = 0; b < LINE_BITS/8; b++) begin
            if (o_byte_en[b]) o_merge_line.bytes[b] = st_line.bytes[b];
        end
    end

    assign word    = i_hit_line.words[i_req_addr[OFFSET_W-1:2]];
    assign shifted = word >> {lane, 3'b000};

    always_comb begin
        unique case (wstrb_q)
            SIZE_BYTE: o_load_data = {{24{signed_q & shifted[7]}}, shifted[7:0]};
            SIZE_HALF: o_load_data = {{16{signed_q & shifted[15]}}, shifted[15:0]};
            default:   o_load_data = word;
        endcase
    end

endmodule

`default_nettype wire

/* logic/dcache_line_buf.sv */
`default_nettype none

module dcache_line_buf import dcache_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 i_ret_capture,
    input  logic [LINE_BITS-1:0] i_mem_rdata,
    input  logic                 i_victim_capture,
    input  cache_line_u          i_victim_line,
    input  logic [TAG_W-1:0]     i_victim_tag,
    input  logic [INDEX_W-1:0]   i_index,
    output cache_line_u          o_ret_line,
    output logic [LINE_BITS-1:0] o_wb_line,
    output logic [31:0]          o_wb_addr
);

    // refill return
    always_ff @(posedge clk) begin
        if (i_ret_capture) o_ret_line <= i_mem_rdata;
    end

    // victim kept apart, the way gets overwritten in REFILL
    always_ff @(posedge clk) begin
        if (i_victim_capture) o_wb_line <= i_victim_line;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_wb_addr <= '0;
        end else if (i_victim_capture) begin
            o_wb_addr <= {i_victim_tag, i_index, {OFFSET_W{1'b0}}};
        end
    end

endmodule

`default_nettype wire

/* logic/dcache_top.sv */
`default_nettype none

module dcache_top import dcache_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,
    // pipeline
    input  logic                 i_rvalid,
    input  logic                 i_wvalid,
    input  logic [31:0]          i_addr,
    input  logic [31:0]          i_wdata,
    input  logic [3:0]           i_wstrb,
    input  logic                 i_signed,
    output logic                 o_rready,
    output logic                 o_wready,
    output logic [31:0]          o_rdata,
    output logic [6:0]           o_exception,
    output logic [31:0]          o_badv,
    // refill channel
    output logic                 o_mem_rvalid,
    input  logic                 i_mem_rready,
    output logic [31:0]          o_mem_raddr,
    input  logic [LINE_BITS-1:0] i_mem_rdata,
    // write-back channel
    output logic                 o_mem_wvalid,
    input  logic                 i_mem_wready,
    output logic [31:0]          o_mem_waddr,
    output logic [LINE_BITS-1:0] o_mem_wdata
);

    logic                   req_capture;
    logic [1:0]             tag_we;
    logic [1:0]             data_we;
    logic                   refill_sel;
    logic                   lru_we;
    logic                   lru_way;
    logic [1:0]             dirty_we;
    logic                   dirty_val;
    logic                   victim_capture;
    logic                   ret_capture;
    logic                   exc_valid;
    logic                   hit;
    logic                   hit_way;
    cache_line_u [1:0]      way_line;
    logic [1:0][TAG_W-1:0]  way_tag;
    logic [31:0]            req_addr;
    logic                   victim_way;
    logic                   victim_dirty;
    logic                   misaligned;
    logic                   req_store;
    logic [LINE_BITS/8-1:0] byte_en;
    cache_line_u            merge_line;
    cache_line_u            ret_line;

    dcache_ctrl u_ctrl (
        .clk              (clk),
        .rstn             (rstn),
        .i_rvalid         (i_rvalid),
        .i_wvalid         (i_wvalid),
        .i_mem_rready     (i_mem_rready),
        .i_mem_wready     (i_mem_wready),
        .i_hit            (hit),
        .i_hit_way        (hit_way),
        .i_victim_way     (victim_way),
        .i_victim_dirty   (victim_dirty),
        .i_misaligned     (misaligned),
        .i_is_store       (req_store),
        .o_rready         (o_rready),
        .o_wready         (o_wready),
        .o_mem_rvalid     (o_mem_rvalid),
        .o_mem_wvalid     (o_mem_wvalid),
        .o_req_capture    (req_capture),
        .o_tag_we         (tag_we),
        .o_data_we        (data_we),
        .o_refill_sel     (refill_sel),
        .o_lru_we         (lru_we),
        .o_lru_way        (lru_way),
        .o_dirty_we       (dirty_we),
        .o_dirty_val      (dirty_val),
        .o_victim_capture (victim_capture),
        .o_ret_capture    (ret_capture),
        .o_exc_valid      (exc_valid)
    );

    dcache_ways u_ways (
        .clk           (clk),
        .rstn          (rstn),
        .i_addr        (i_addr),
        .i_req_capture (req_capture),
        .i_tag_we      (tag_we),
        .i_data_we     (data_we),
        .i_byte_en     (byte_en),
        .i_refill_sel  (refill_sel),
        .i_line_wdata  (merge_line),
        .o_hit         (hit),
        .o_hit_way     (hit_way),
        .o_way_line    (way_line),
        .o_way_tag     (way_tag),
        .o_req_addr    (req_addr)
    );

    dcache_repl u_repl (
        .clk            (clk),
        .rstn           (rstn),
        .i_index        (req_addr[OFFSET_W +: INDEX_W]),
        .i_lru_we       (lru_we),
        .i_lru_way      (lru_way),
        .i_dirty_we     (dirty_we),
        .i_dirty_val    (dirty_val),
        .o_victim_way   (victim_way),
        .o_victim_dirty (victim_dirty)
    );

    dcache_align u_align (
        .clk           (clk),
        .i_req_capture (req_capture),
        .i_is_store    (i_wvalid),
        .i_wdata       (i_wdata),
        .i_wstrb       (i_wstrb),
        .i_signed      (i_signed),
        .i_req_addr    (req_addr),
        .i_src_line    (ret_line),
        .i_hit_line    (way_line[hit_way]),
        .o_req_store   (req_store),
        .o_misaligned  (misaligned),
        .o_byte_en     (byte_en),
        .o_merge_line  (merge_line),
        .o_load_data   (o_rdata)
    );

    dcache_line_buf u_line_buf (
        .clk              (clk),
        .rstn             (rstn),
        .i_ret_capture    (ret_capture),
        .i_mem_rdata      (i_mem_rdata),
        .i_victim_capture (victim_capture),
        .i_victim_line    (way_line[victim_way]),
        .i_victim_tag     (way_tag[victim_way]),
        .i_index          (req_addr[OFFSET_W +: INDEX_W]),
        .o_ret_line       (ret_line),
        .o_wb_line        (o_mem_wdata),
        .o_wb_addr        (o_mem_waddr)
    );

    assign o_mem_raddr = {req_addr[31:OFFSET_W], {OFFSET_W{1'b0}}};  // line aligned
    assign o_exception = exc_valid ? EXC_ALE : EXC_NONE;
    assign o_badv      = exc_valid ? req_addr : '0;

endmodule

`default_nettype wire

/* tb/dcache_tb.sv */
`default_nettype none

module dcache_tb import dcache_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] BASE      = 32'h0040_0000;
    localparam int          MEM_BYTES = 16384;   // 4 tags x 64 sets x 64 bytes
    localparam int          WAIT_MAX  = 200;
    localparam logic [15:0] SEED      = 16'd50;

    logic                 clk;
    logic                 rstn;
    logic                 i_rvalid;
    logic                 i_wvalid;
    logic [31:0]          i_addr;
    logic [31:0]          i_wdata;
    logic [3:0]           i_wstrb;
    logic                 i_signed;
    logic                 o_rready;
    logic                 o_wready;
    logic [31:0]          o_rdata;
    logic [6:0]           o_exception;
    logic [31:0]          o_badv;
    logic                 o_mem_rvalid;
    logic                 i_mem_rready;
    logic [31:0]          o_mem_raddr;
    logic [LINE_BITS-1:0] i_mem_rdata;
    logic                 o_mem_wvalid;
    logic                 i_mem_wready;
    logic [31:0]          o_mem_waddr;
    logic [LINE_BITS-1:0] o_mem_wdata;

    logic [7:0] shadow   [MEM_BYTES];   // what the program has written
    logic [7:0] main_mem [MEM_BYTES];   // what memory holds

    int          errors;
    int          other_errs;
    int          timeouts;
    int          checks;
    int          rd_count;
    int          wb_count;
    int          lat;        // cycles taken by the last request
    logic [31:0] last_waddr;

    // request in flight
    logic        active;
    logic        done;
    logic        exp_store;
    logic [6:0]  exp_exc;
    logic [31:0] exp_rdata;
    logic [31:0] exp_badv;

    logic [15:0] rd_lfsr;
    logic [15:0] wr_lfsr;
    logic [15:0] st_lfsr;

    dcache_top uut (
        .clk          (clk),
        .rstn         (rstn),
        .i_rvalid     (i_rvalid),
        .i_wvalid     (i_wvalid),
        .i_addr       (i_addr),
        .i_wdata      (i_wdata),
        .i_wstrb      (i_wstrb),
        .i_signed     (i_signed),
        .o_rready     (o_rready),
        .o_wready     (o_wready),
        .o_rdata      (o_rdata),
        .o_exception  (o_exception),
        .o_badv       (o_badv),
        .o_mem_rvalid (o_mem_rvalid),
        .i_mem_rready (i_mem_rready),
        .o_mem_raddr  (o_mem_raddr),
        .i_mem_rdata  (i_mem_rdata),
        .o_mem_wvalid (o_mem_wvalid),
        .i_mem_wready (i_mem_wready),
        .o_mem_waddr  (o_mem_waddr),
        .o_mem_wdata  (o_mem_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11
    endfunction

    // one step per bit taken
    task automatic take_bits(input int n, inout logic [15:0] st, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            st  = lfsr_step(st);
            val = {val[30:0], st[0]};
        end
    endtask

    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        logic [31:0] h;
        h = a * 32'h9E37_79B1;
        return h[31:24] ^ h[15:8];
    endfunction

    function automatic logic bad_align(input logic [31:0] a, input logic [3:0] strb);
        return (strb == SIZE_HALF && a[0]) || (strb == SIZE_WORD && a[1:0] != 2'b00);
    endfunction

    // expected load data, little endian from the shadow memory
    function automatic logic [31:0] ref_load(input logic [31:0] a, input logic [3:0] strb,
                                            input logic sgn);
        int p;
        p = a[13:0];
        case (strb)
            SIZE_BYTE: return {{24{sgn & shadow[p][7]}}, shadow[p]};
            SIZE_HALF: return {{16{sgn & shadow[p+1][7]}}, shadow[p+1], shadow[p]};
            default:   return {shadow[p+3], shadow[p+2], shadow[p+1], shadow[p]};
        endcase
    endfunction

    function automatic cache_line_u read_line(input logic [31:0] a, input logic from_shadow);
        cache_line_u l;
        int          p;
        p = a[13:6] * 64;
        for (int b = 0; b < 64; b++) begin
            l.bytes[b] = from_shadow ? shadow[p + b] : main_mem[p + b];
        end
        return l;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_exception(input logic [6:0] got, input logic [6:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t o_exception got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic verify_line(input string name, input cache_line_u got,
                               input cache_line_u exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic note_error(input string msg);
        other_errs++;
        $display("%0t error: %s", $time, msg);
    endtask

    task automatic finish_run();
        $display("checks %0d, value errors %0d, other errors %0d, timeouts %0d",
                 checks, errors, other_errs, timeouts);
        if (errors == 0 && other_errs == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    // issue one request and hold it until its ready
    task automatic access(input logic st, input logic [31:0] a, input logic [3:0] strb,
                          input logic sgn, input logic [31:0] data);
        logic bad;
        bad       = bad_align(a, strb);
        exp_store = st;
        exp_exc   = bad ? EXC_ALE : EXC_NONE;
        exp_badv  = a;
        exp_rdata = ref_load(a, strb, sgn);
        done      = 1'b0;
        active    = 1'b1;
        i_rvalid <= !st;
        i_wvalid <= st;
        i_addr   <= a;
        i_wdata  <= data;
        i_wstrb  <= strb;
        i_signed <= sgn;
        lat = 0;
        while (!done && lat < WAIT_MAX) begin
            @(posedge clk);
            lat++;
        end
        if (!done) begin
            timeouts++;
            $display("%0t no ready for the request at %h after %0d cycles", $time, a, lat);
            finish_run();
        end else begin
            if (st && !bad) begin
                for (int b = 0; b < 4; b++) begin
                    if (strb[b]) shadow[a[13:0] + b] = data[8*b +: 8];
                end
            end
            i_rvalid <= 1'b0;
            i_wvalid <= 1'b0;
            @(posedge clk);   // a hit is looked up once more here, its ready is ignored
        end
    endtask

    // compare at the falling edge, away from the driving edge
    always @(negedge clk) begin
        if (active && (o_rready || o_wready)) begin
            if (o_wready !== exp_store || o_rready !== !exp_store) begin
                note_error("ready of the wrong kind for the request");
            end
            compare_exception(o_exception, exp_exc);
            if (exp_exc != EXC_NONE) begin
                check_word("o_badv", o_badv, exp_badv);
            end else if (!exp_store) begin
                check_word("o_rdata", o_rdata, exp_rdata);
            end
            active = 1'b0;
            done   = 1'b1;
        end
    end

    initial begin : refill_model
        logic [31:0] d;
        logic [31:0] a;
        forever begin
            @(negedge clk);
            if (rstn && o_mem_rvalid === 1'b1) begin
                rd_count++;
                a = o_mem_raddr;
                take_bits(3, rd_lfsr, d);
                for (int i = 0; i < d; i++) begin
                    @(negedge clk);
                    if (o_mem_rvalid !== 1'b1) note_error("refill request dropped early");
                end
                @(posedge clk);
                i_mem_rready <= 1'b1;
                i_mem_rdata  <= read_line(a, 1'b0);
                @(posedge clk);
                i_mem_rready <= 1'b0;
            end
        end
    end

    initial begin : writeback_model
        logic [31:0] d;
        logic [31:0] a;
        cache_line_u l;
        int          p;
        forever begin
            @(negedge clk);
            if (rstn && o_mem_wvalid === 1'b1) begin
                wb_count++;
                a          = o_mem_waddr;
                l          = o_mem_wdata;
                last_waddr = a;
                p          = a[13:6] * 64;
                check_word("o_mem_waddr", a & 32'hFFFF_C03F, BASE);   // base bits, zero offset
                verify_line("o_mem_wdata", l, read_line(a, 1'b1));
                for (int b = 0; b < 64; b++) begin
                    main_mem[p + b] = l.bytes[b];
                end
                take_bits(3, wr_lfsr, d);
                for (int i = 0; i < d; i++) begin
                    @(negedge clk);
                    if (o_mem_wvalid !== 1'b1) note_error("write-back dropped early");
                end
                @(posedge clk);
                i_mem_wready <= 1'b1;
                @(posedge clk);
                i_mem_wready <= 1'b0;
            end
        end
    end

    initial begin : stimulus
        logic [31:0] a;
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] off;
        logic [3:0]  strb;
        int          rd0;
        int          wb0;
        rstn         = 1'b0;
        i_rvalid     = 1'b0;
        i_wvalid     = 1'b0;
        i_addr       = '0;
        i_wdata      = '0;
        i_wstrb      = SIZE_WORD;
        i_signed     = 1'b0;
        i_mem_rready = 1'b0;
        i_mem_rdata  = '0;
        i_mem_wready = 1'b0;
        errors       = 0;
        other_errs   = 0;
        timeouts     = 0;
        checks       = 0;
        rd_count     = 0;
        wb_count     = 0;
        lat          = 0;
        last_waddr   = '0;
        active       = 1'b0;
        done         = 1'b0;
        rd_lfsr      = SEED;
        wr_lfsr      = SEED;
        st_lfsr      = SEED;
        for (int i = 0; i < MEM_BYTES; i++) begin
            shadow[i]   = fill_byte(BASE + i);
            main_mem[i] = shadow[i];
        end
        repeat (8) @(posedge clk);
        rstn <= 1'b1;

        // quiet after reset
        repeat (4) begin
            @(negedge clk);
            if (o_rready !== 1'b0 || o_wready !== 1'b0) note_error("ready before any request");
            if (o_mem_rvalid !== 1'b0 || o_mem_wvalid !== 1'b0) begin
                note_error("memory valid before any request");
            end
            compare_exception(o_exception, EXC_NONE);
        end
        @(posedge clk);

        // first touch misses, the repeat hits
        a   = BASE + 32'h0008;
        rd0 = rd_count;
        access(1'b0, a, SIZE_WORD, 1'b0, '0);
        if (rd_count != rd0 + 1) note_error("first load did not refill its line");
        access(1'b0, a, SIZE_WORD, 1'b0, '0);
        if (lat != 2) note_error($sformatf("repeat load took %0d cycles, not 2", lat));
        if (rd_count != rd0 + 1) note_error("repeat load refilled again");

        // every byte and halfword lane, two words
        a = BASE + 32'h0100;
        access(1'b1, a, SIZE_WORD, 1'b0, 32'h7F7E_F081);
        for (int lane = 0; lane < 8; lane++) begin
            for (int s = 0; s < 2; s++) begin
                access(1'b0, a + lane, SIZE_BYTE, s[0], '0);
                if (lane % 2 == 0) access(1'b0, a + lane, SIZE_HALF, s[0], '0);
            end
        end

        // stores of each size, then three tags on set 5
        a = BASE + 32'h0140;
        access(1'b1, a + 1, SIZE_BYTE, 1'b0, 32'h0000_00A5);
        access(1'b1, a + 6, SIZE_HALF, 1'b0, 32'h0000_BEEF);
        access(1'b1, a + 8, SIZE_WORD, 1'b0, 32'h1234_5678);
        for (int w = 0; w < 3; w++) begin
            access(1'b0, a + 4 * w, SIZE_WORD, 1'b0, '0);
        end
        wb0 = wb_count;
        access(1'b0, a + 32'h1000, SIZE_WORD, 1'b0, '0);   // fills the empty way
        if (wb_count != wb0) note_error("fill of an empty way caused a write-back");
        access(1'b0, a + 32'h2000, SIZE_WORD, 1'b0, '0);   // dirty store line goes
        if (wb_count != wb0 + 1) begin
            note_error("dirty victim was not written back");
        end else begin
            check_word("o_mem_waddr", last_waddr, a);
        end
        access(1'b0, a + 8, SIZE_WORD, 1'b0, '0);          // clean victim this time
        if (wb_count != wb0 + 1) note_error("clean victim caused a write-back");

        // misaligned accesses
        a   = a + 32'h3000;   // a line the cache does not hold
        rd0 = rd_count;
        wb0 = wb_count;
        access(1'b0, a + 3, SIZE_HALF, 1'b1, '0);
        access(1'b1, a + 2, SIZE_WORD, 1'b0, 32'hDEAD_BEEF);
        access(1'b0, a + 5, SIZE_WORD, 1'b0, '0);
        if (rd_count != rd0 || wb_count != wb0) begin
            note_error("misaligned access started a memory transfer");
        end
        access(1'b0, a, SIZE_WORD, 1'b0, '0);
        access(1'b0, a + 4, SIZE_WORD, 1'b0, '0);

        // random mix over 4 tags and 4 sets
        for (int n = 0; n < 200; n++) begin
            take_bits(8, st_lfsr, r);   // store, size, sign, set, tag
            take_bits(6, st_lfsr, off);
            take_bits(32, st_lfsr, d);
            case (r[2:1])
                2'd0:    strb = SIZE_BYTE;
                2'd1:    strb = SIZE_HALF;
                default: strb = SIZE_WORD;
            endcase
            if (strb == SIZE_HALF) off[0] = 1'b0;
            if (strb == SIZE_WORD) off[1:0] = 2'b00;
            a = BASE + {r[7:6], 4'b0000, r[5:4], off[5:0]};
            access(r[0], a, strb, r[3], d);
        end

        finish_run();
    end

endmodule

`default_nettype wire

/* sources.f */
logic/dcache_pkg.sv
logic/dcache_ctrl.sv
logic/dcache_ways.sv
logic/dcache_repl.sv
logic/dcache_align.sv
logic/dcache_line_buf.sv
logic/dcache_top.sv
tb/dcache_tb.sv
